// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_ex_stage
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ex_stage_assert.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage_assert import ex_pkg::*; (
    input logic     clk_i,
    input logic     rst_i,
    input mem_req_t mem_req_i,
    input logic     wb_valid_i,
    input logic     reg_we_i,
    input logic     jump_flag_i,
    input word_t    jump_addr_i
);

    // flags low one cycle after a reset edge
    a_reset_flags: assert property (@(posedge clk_i)
        rst_i |=> (!wb_valid_i && !reg_we_i && !jump_flag_i))
        else $error("output flags set after reset");

    a_be_needs_we: assert property (@(posedge clk_i)
        !mem_req_i.we |-> (mem_req_i.be == 4'b0000))
        else $error("byte enables raised without a write");

    a_jaddr_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !jump_flag_i |-> (jump_addr_i == '0))
        else $error("jump address nonzero without a jump");

    a_we_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        reg_we_i |-> wb_valid_i)
        else $error("register write without writeback valid");

endmodule

bind ex_stage ex_stage_assert u_ex_stage_assert (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_i   (mem_req_o),
    .wb_valid_i  (wb_valid_o),
    .reg_we_i    (reg_we_o),
    .jump_flag_i (jump_flag_o),
    .jump_addr_i (jump_addr_o)
);

`default_nettype wire

// File: bench/tb_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

    localparam int    CLK_PERIOD = 100;
    localparam int    RST_CYCLES = 3;
    localparam word_t LD_WORD    = 32'h5EA3_F017; // mixed sign bytes and halves

    typedef struct packed {
        ex_req_t  req;
        word_t    rdata;
        logic     we;    // expected values from here on
        word_t    wdata;
        logic     jump;
        word_t    jaddr;
        mem_req_t mem;
    } entry_t;

    logic      clk;
    logic      rst;
    ex_req_t   ex_req;
    word_t     mem_rdata;
    mem_req_t  mem_req;
    logic      wb_valid;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata;
    logic      jump_flag;
    word_t     jump_addr;

    entry_t tbl[$];
    string  names[$];
    int     errs[$];
    int     n_err;

    ex_stage DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .ex_req_i    (ex_req),
        .mem_rdata_i (mem_rdata),
        .mem_req_o   (mem_req),
        .wb_valid_o  (wb_valid),
        .reg_we_o    (reg_we),
        .reg_waddr_o (reg_waddr),
        .reg_wdata_o (reg_wdata),
        .jump_flag_o (jump_flag),
        .jump_addr_o (jump_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic entry_t base(logic vld, logic [6:0] opc, logic [2:0] f3, logic [6:0] f7,
                                    word_t op1, word_t op2, logic we, word_t wdata);
        entry_t e;
        e = '0;
        e.req.valid         = vld;
        e.req.inst.r.opcode = opc;
        e.req.inst.r.funct3 = f3;
        e.req.inst.r.funct7 = f7; // imm12[11:5] in the i view
        e.req.op1           = op1;
        e.req.op2           = op2;
        e.req.reg_we        = we;
        e.req.rd            = reg_addr_t'(tbl.size() % 31 + 1);
        e.we                = vld & we;
        e.wdata             = wdata;
        return e;
    endfunction

    task automatic push(string name, entry_t e);
        tbl.push_back(e);
        names.push_back(name);
        errs.push_back(0);
    endtask

    task automatic alu(string name, logic [6:0] opc, logic [2:0] f3, logic [6:0] f7,
                       word_t op1, word_t op2, word_t exp);
        push(name, base(1'b1, opc, f3, f7, op1, op2, 1'b1, exp));
    endtask

    // target is always 0x800 - 0x10
    task automatic br(string name, logic [2:0] f3, word_t op1, word_t op2, logic taken);
        entry_t e;
        e = base(1'b1, OPC_BRANCH, f3, 7'd0, op1, op2, 1'b0, '0);
        e.req.jop1 = 32'h0000_0800;
        e.req.jop2 = 32'hFFFF_FFF0;
        e.jump     = taken;
        e.jaddr    = taken ? 32'h0000_07F0 : '0;
        push(name, e);
    endtask

    task automatic jmp(string name, logic [6:0] opc, word_t jop1, word_t jop2, word_t target);
        entry_t e;
        e = base(1'b1, opc, 3'd0, 7'd0, 32'h0000_0100, 32'd4, 1'b1, 32'h0000_0104);
        e.req.jop1 = jop1;
        e.req.jop2 = jop2;
        e.jump     = 1'b1;
        e.jaddr    = target;
        push(name, e);
    endtask

    task automatic ld(string name, logic [2:0] f3, word_t off, word_t exp);
        entry_t e;
        e = base(1'b1, OPC_LOAD, f3, 7'd0, 32'h1000_0400, off, 1'b1, exp);
        e.rdata    = LD_WORD;
        e.mem.req  = 1'b1;
        e.mem.addr = 32'h1000_0400;
        push(name, e);
    endtask

    task automatic st(string name, logic [2:0] f3, word_t off, logic [3:0] be, word_t wdata);
        entry_t e;
        e = base(1'b1, OPC_STORE, f3, 7'd0, 32'h1000_0800, off, 1'b0, '0);
        e.req.rs2_data = 32'hCAFE_BABE;
        e.mem.req      = 1'b1;
        e.mem.we       = 1'b1;
        e.mem.be       = be;
        e.mem.addr     = 32'h1000_0800;
        e.mem.wdata    = wdata;
        push(name, e);
    endtask

    task automatic build_table();
        alu("add", OPC_OP, F3_ADD, 7'd0, 32'hFFFF_FFF6, 32'd7, 32'hFFFF_FFFD);
        alu("sub", OPC_OP, F3_ADD, F7_ALT, 32'hFFFF_FFF6, 32'd7, 32'hFFFF_FFEF);
        alu("xor", OPC_OP, F3_XOR, 7'd0, 32'hFFFF_FFF6, 32'd7, 32'hFFFF_FFF1);
        alu("or", OPC_OP, F3_OR, 7'd0, 32'hFFFF_FFF6, 32'd7, 32'hFFFF_FFF7);
        alu("and", OPC_OP, F3_AND, 7'd0, 32'hFFFF_FFF6, 32'd7, 32'h0000_0006);
        alu("slt", OPC_OP, F3_SLT, 7'd0, 32'hFFFF_FFF6, 32'd7, 32'd1);
        alu("sltu", OPC_OP, F3_SLTU, 7'd0, 32'hFFFF_FFF6, 32'd7, 32'd0);
        alu("addi", OPC_OP_IMM, F3_ADD, 7'd0, 32'h0000_1234, 32'hFFFF_FF80, 32'h0000_11B4);
        alu("xori", OPC_OP_IMM, F3_XOR, 7'd0, 32'h0000_1234, 32'hFFFF_FF80, 32'hFFFF_EDB4);
        alu("andi", OPC_OP_IMM, F3_AND, 7'd0, 32'h0000_1234, 32'hFFFF_FF80, 32'h0000_1200);
        alu("slti", OPC_OP_IMM, F3_SLT, 7'd0, 32'h0000_1234, 32'hFFFF_FF80, 32'd0);
        alu("sltiu", OPC_OP_IMM, F3_SLTU, 7'd0, 32'h0000_1234, 32'hFFFF_FF80, 32'd1);
        alu("sll", OPC_OP, F3_SLL, 7'd0, 32'h8000_00F0, 32'h0000_0104, 32'h0000_0F00);
        alu("srl", OPC_OP, F3_SR, 7'd0, 32'h8000_00F0, 32'h0000_0104, 32'h0800_000F);
        alu("sra", OPC_OP, F3_SR, F7_ALT, 32'h8000_00F0, 32'h0000_0104, 32'hF800_000F);
        alu("slli", OPC_OP_IMM, F3_SLL, 7'd0, 32'h8000_00F0, 32'd8, 32'h0000_F000);
        alu("srli", OPC_OP_IMM, F3_SR, 7'd0, 32'h8000_00F0, 32'd8, 32'h0080_0000);
        alu("srai", OPC_OP_IMM, F3_SR, F7_ALT, 32'h8000_00F0, 32'h0000_0408, 32'hFF80_0000);
        br("beq_t", F3_BEQ, 32'd5, 32'd5, 1'b1);
        br("beq_n", F3_BEQ, 32'd5, 32'd6, 1'b0);
        br("bne_t", F3_BNE, 32'd5, 32'd6, 1'b1);
        br("bne_n", F3_BNE, 32'd5, 32'd5, 1'b0);
        br("blt_t", F3_BLT, 32'hFFFF_FFFF, 32'd1, 1'b1);
        br("blt_n", F3_BLT, 32'd1, 32'hFFFF_FFFF, 1'b0);
        br("bge_t", F3_BGE, 32'd1, 32'hFFFF_FFFF, 1'b1);
        br("bge_n", F3_BGE, 32'hFFFF_FFFF, 32'd1, 1'b0);
        br("bltu_t", F3_BLTU, 32'd1, 32'hFFFF_FFFF, 1'b1);
        br("bltu_n", F3_BLTU, 32'hFFFF_FFFF, 32'd1, 1'b0);
        br("bgeu_t", F3_BGEU, 32'hFFFF_FFFF, 32'd1, 1'b1);
        br("bgeu_n", F3_BGEU, 32'd1, 32'hFFFF_FFFF, 1'b0);
        jmp("jal", OPC_JAL, 32'h0000_0100, 32'h0000_003C, 32'h0000_013C);
        jmp("jalr", OPC_JALR, 32'h0000_2001, 32'h0000_0010, 32'h0000_2010); // bit 0 dropped
        ld("lb_0", F3_B, 32'd0, 32'h0000_0017);
        ld("lb_1", F3_B, 32'd1, 32'hFFFF_FFF0);
        ld("lb_2", F3_B, 32'd2, 32'hFFFF_FFA3);
        ld("lb_3", F3_B, 32'd3, 32'h0000_005E);
        ld("lbu_0", F3_BU, 32'd0, 32'h0000_0017);
        ld("lbu_1", F3_BU, 32'd1, 32'h0000_00F0);
        ld("lbu_2", F3_BU, 32'd2, 32'h0000_00A3);
        ld("lbu_3", F3_BU, 32'd3, 32'h0000_005E);
        ld("lh_0", F3_H, 32'd0, 32'hFFFF_F017);
        ld("lh_2", F3_H, 32'd2, 32'h0000_5EA3);
        ld("lhu_0", F3_HU, 32'd0, 32'h0000_F017);
        ld("lhu_2", F3_HU, 32'd2, 32'h0000_5EA3);
        ld("lw", F3_W, 32'd0, 32'h5EA3_F017);
        st("sb_0", F3_B, 32'd0, 4'b0001, 32'hBEBE_BEBE);
        st("sb_1", F3_B, 32'd1, 4'b0010, 32'hBEBE_BEBE);
        st("sb_2", F3_B, 32'd2, 4'b0100, 32'hBEBE_BEBE);
        st("sb_3", F3_B, 32'd3, 4'b1000, 32'hBEBE_BEBE);
        st("sh_0", F3_H, 32'd0, 4'b0011, 32'hBABE_BABE);
        st("sh_2", F3_H, 32'd2, 4'b1100, 32'hBABE_BABE);
        st("sw", F3_W, 32'd0, 4'b1111, 32'hCAFE_BABE);
        // valid low with reg_we set
        push("idle_store", base(1'b0, OPC_STORE, F3_W, 7'd0, 32'h1000_0800, '0, 1'b1, '0));
        push("idle_jal", base(1'b0, OPC_JAL, 3'd0, 7'd0, 32'h0000_0100, 32'd4, 1'b1, '0));
    endtask

    task automatic check(int k, string sig, word_t exp, word_t act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, sig, exp, act);
            errs[k] = errs[k] + 1;
            n_err = n_err + 1;
        end
    endtask

    task automatic check_mem(int k);
        entry_t e;
        e = tbl[k];
        check(k, "mem_req_o.req", 32'(e.mem.req), 32'(mem_req.req));
        check(k, "mem_req_o.we", 32'(e.mem.we), 32'(mem_req.we));
        check(k, "mem_req_o.be", 32'(e.mem.be), 32'(mem_req.be));
        if (e.mem.req) begin
            check(k, "mem_req_o.addr", e.mem.addr, mem_req.addr);
        end
        if (e.mem.we) begin
            check(k, "mem_req_o.wdata", e.mem.wdata, mem_req.wdata);
        end
    endtask

    task automatic finish_entry(int k);
        entry_t e;
        e = tbl[k];
        check(k, "wb_valid_o", 32'(e.req.valid), 32'(wb_valid));
        check(k, "reg_we_o", 32'(e.we), 32'(reg_we));
        check(k, "jump_flag_o", 32'(e.jump), 32'(jump_flag));
        check(k, "jump_addr_o", e.jaddr, jump_addr);
        if (e.req.valid) begin
            check(k, "reg_waddr_o", 32'(e.req.rd), 32'(reg_waddr));
            check(k, "reg_wdata_o", e.wdata, reg_wdata);
        end
        if (errs[k] == 0) begin
            $display("%s: ok", names[k]);
        end else begin
            $display("%s: %0d mismatches", names[k], errs[k]);
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk       = 1'b0;
        rst       = 1'b1;
        ex_req    = '0;
        mem_rdata = '0;
        n_err     = 0;
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (wb_valid !== 1'b0 || reg_we !== 1'b0 || jump_flag !== 1'b0) begin
            $display("reset did not clear wb_valid_o, reg_we_o and jump_flag_o");
            n_err = n_err + 1;
        end else begin
            $display("reset: ok");
        end
        for (int k = 0; k < tbl.size(); k++) begin
            @(posedge clk);
            ex_req    <= tbl[k].req;
            mem_rdata <= tbl[k].rdata;
            @(negedge clk);
            check_mem(k);
            if (k > 0) begin
                finish_entry(k - 1); // overlaps with entry k at the input
            end
        end
        @(posedge clk);
        ex_req    <= '0;
        mem_rdata <= '0;
        @(negedge clk);
        finish_entry(tbl.size() - 1);
        $display("%0d entries run, %0d errors", tbl.size(), n_err);
        if (n_err == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #1;
        #((tbl.size() + RST_CYCLES + 10) * CLK_PERIOD);
        $display("timeout: the table did not run to its end in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/ex_pkg.sv
source/alu_branch.sv
source/lsu_align.sv
source/ex_writeback.sv
source/ex_stage.sv
bench/ex_stage_assert.sv
bench/tb_ex_stage.sv

// File: source/alu_branch.sv
`timescale 1ns/10ps
`default_nettype none

module alu_branch import ex_pkg::*; (
    input  ex_req_t  req_i,
    output alu_res_t alu_res_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_op;
    logic       alt_r;
    logic       alt_i;
    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    word_t      sll_res;
    word_t      srl_res;
    word_t      sra_res;
    logic       lt_s;
    logic       lt_u;
    logic       eq;
    word_t      alu_word;
    logic       take;
    word_t      target;
    word_t      wdata;
    logic       jump;

    assign opcode = req_i.inst.r.opcode;
    assign funct3 = req_i.inst.r.funct3;
    assign is_op  = (opcode == OPC_OP);

    // same bits, read through the two instruction formats
    assign alt_r = (req_i.inst.r.funct7 == F7_ALT);      // sub
    assign alt_i = (req_i.inst.i.imm12[11:5] == F7_ALT); // sra / srai

    assign shamt = req_i.op2[4:0];

    assign sum     = req_i.op1 + req_i.op2;
    assign diff    = req_i.op1 - req_i.op2;
    assign sll_res = req_i.op1 << shamt;
    assign srl_res = req_i.op1 >> shamt;
    assign sra_res = word_t'($signed(req_i.op1) >>> shamt); // sign fill

    assign lt_s = ($signed(req_i.op1) < $signed(req_i.op2));
    assign lt_u = (req_i.op1 < req_i.op2);
    assign eq   = (req_i.op1 == req_i.op2);

    always_comb begin
        case (funct3)
            F3_ADD:  alu_word = (is_op && alt_r) ? diff : sum;
            F3_SLL:  alu_word = sll_res;
            F3_SLT:  alu_word = {31'b0, lt_s};
            F3_SLTU: alu_word = {31'b0, lt_u};
            F3_XOR:  alu_word = req_i.op1 ^ req_i.op2;
            F3_SR:   alu_word = alt_i ? sra_res : srl_res;
            F3_OR:   alu_word = req_i.op1 | req_i.op2;
            F3_AND:  alu_word = req_i.op1 & req_i.op2;
            default: alu_word = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  take = eq;
            F3_BNE:  take = ~eq;
            F3_BLT:  take = lt_s;
            F3_BGE:  take = ~lt_s;
            F3_BLTU: take = lt_u;
            F3_BGEU: take = ~lt_u;
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        wdata = '0;
        jump  = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                wdata = alu_word;
            end
            OPC_BRANCH: begin
                jump = take;
            end
            OPC_JAL, OPC_JALR: begin
                wdata = sum; // link value from decoder
                jump  = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                wdata = sum;
            end
            default: begin
                wdata = '0; // loads, stores, unknown
            end
        endcase
    end

    always_comb begin
        target = req_i.jop1 + req_i.jop2;
        if (opcode == OPC_JALR) begin
            target[0] = 1'b0;
        end
    end

    assign alu_res_o.wdata     = wdata;
    assign alu_res_o.jump      = jump;
    assign alu_res_o.jump_addr = jump ? target : '0;

endmodule

`default_nettype wire

// File: source/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load / store sizes
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        logic      valid;
        inst_u     inst;
        word_t     op1;      // rs1
        word_t     op2;      // rs2 or immediate
        word_t     jop1;     // jump base
        word_t     jop2;     // jump offset
        word_t     rs2_data; // store data
        logic      reg_we;
        reg_addr_t rd;
    } ex_req_t;

    typedef struct packed {
        word_t wdata;
        logic  jump;
        word_t jump_addr;
    } alu_res_t;

    typedef struct packed {
        logic  is_load;
        word_t load_data;
    } lsu_res_t;

    typedef struct packed {
        logic       req;
        logic       we;
        logic [3:0] be;
        word_t      addr;  // word aligned
        word_t      wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: source/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  ex_req_t   ex_req_i,
    input  word_t     mem_rdata_i,
    output mem_req_t  mem_req_o,
    output logic      wb_valid_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output word_t     reg_wdata_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    alu_res_t alu_res;
    lsu_res_t lsu_res;

    // both units see the same request
    alu_branch u_alu_branch (
        .req_i     (ex_req_i),
        .alu_res_o (alu_res)
    );

    lsu_align u_lsu_align (
        .req_i       (ex_req_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_req_o   (mem_req_o),
        .lsu_res_o   (lsu_res)
    );

    ex_writeback u_ex_writeback (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (ex_req_i.valid),
        .reg_we_i    (ex_req_i.reg_we),
        .rd_i        (ex_req_i.rd),
        .alu_res_i   (alu_res),
        .lsu_res_i   (lsu_res),
        .wb_valid_o  (wb_valid_o),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

endmodule

`default_nettype wire

// File: source/ex_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module ex_writeback import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      valid_i,
    input  logic      reg_we_i,
    input  reg_addr_t rd_i,
    input  alu_res_t  alu_res_i,
    input  lsu_res_t  lsu_res_i,
    output logic      wb_valid_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output word_t     reg_wdata_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    word_t wb_word;
    logic  jump;

    assign wb_word = lsu_res_i.is_load ? lsu_res_i.load_data : alu_res_i.wdata;
    assign jump    = valid_i & alu_res_i.jump;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o  <= 1'b0;
            reg_we_o    <= 1'b0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            wb_valid_o  <= valid_i;
            reg_we_o    <= valid_i & reg_we_i;
            jump_flag_o <= jump;
            jump_addr_o <= jump ? alu_res_i.jump_addr : '0; // zero unless jumping
        end
    end

    always_ff @(posedge clk_i) begin
        reg_waddr_o <= rd_i;
        reg_wdata_o <= wb_word;
    end

endmodule

`default_nettype wire

// File: source/lsu_align.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_align import ex_pkg::*; (
    input  ex_req_t  req_i,
    input  word_t    mem_rdata_i,
    output mem_req_t mem_req_o,
    output lsu_res_t lsu_res_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    word_t       eff_addr;
    logic [1:0]  lane;
    logic        is_load;
    logic        is_store;
    logic [3:0]  be;
    word_t       st_data;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       ld_data;

    assign opcode = req_i.inst.i.opcode;
    assign funct3 = req_i.inst.i.funct3;

    assign eff_addr = req_i.op1 + req_i.op2;
    assign lane     = eff_addr[1:0];

    assign is_load  = req_i.valid && (opcode == OPC_LOAD);
    assign is_store = req_i.valid && (opcode == OPC_STORE);

    // byte enables per size and lane
    always_comb begin
        case (funct3)
            F3_B:    be = 4'b0001 << lane;
            F3_H:    be = lane[1] ? 4'b1100 : 4'b0011;
            F3_W:    be = 4'b1111;
            default: be = 4'b0000;
        endcase
    end

    // replicate so every lane carries the data, be picks the target
    always_comb begin
        case (funct3)
            F3_B:    st_data = {4{req_i.rs2_data[7:0]}};
            F3_H:    st_data = {2{req_i.rs2_data[15:0]}};
            default: st_data = req_i.rs2_data;
        endcase
    end

    assign ld_byte = mem_rdata_i[{lane, 3'b000} +: 8];
    assign ld_half = mem_rdata_i[{lane[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            F3_B:    ld_data = {{24{ld_byte[7]}}, ld_byte};
            F3_BU:   ld_data = {24'b0, ld_byte};
            F3_H:    ld_data = {{16{ld_half[15]}}, ld_half};
            F3_HU:   ld_data = {16'b0, ld_half};
            F3_W:    ld_data = mem_rdata_i;
            default: ld_data = '0;
        endcase
    end

    always_comb begin
        mem_req_o.req   = is_load | is_store;
        mem_req_o.we    = is_store;
        mem_req_o.be    = is_store ? be : 4'b0000;
        mem_req_o.addr  = (is_load | is_store) ? {eff_addr[XLEN-1:2], 2'b00} : '0;
        mem_req_o.wdata = is_store ? st_data : '0;
    end

    assign lsu_res_o.is_load   = is_load;
    assign lsu_res_o.load_data = ld_data;

endmodule

`default_nettype wire
